/* include/peri_config.svh */
/*
 * Bus widths, slot counts and GPIO register offsets for the peripheral hub.
 * Include wherever these constants are needed.
 */

`ifndef PERI_CONFIG_SVH
`define PERI_CONFIG_SVH

// Core bus
`define PERI_ADDR_W 11
`define PERI_DATA_W 32

// Slot counts
`define PERI_NUM_SIMPLE 8   // Simple byte slots with 16-byte windows
`define PERI_NUM_USER   16  // Full slot indices with 64-byte windows

// Output pins
`define PERI_PINS 8

// GPIO register offsets within its full window
`define GPIO_OFS_OUT  6'h00
`define GPIO_OFS_IN   6'h04
`define GPIO_OFS_FSEL 6'h20 // One word per pin from here

`endif

/* hw/peri_bus_pkg.sv */
/*
 * Types seen on the core side of the hub: access sizes, the bus request
 * and the decoded slot selection.
 */

`include "peri_config.svh"

package peri_bus_pkg;

    // Size codes as driven by the core where all ones means idle
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } access_size_e;

    typedef struct packed {
        logic [`PERI_ADDR_W-1:0] addr;
        logic [`PERI_DATA_W-1:0] wdata;
        access_size_e            wsize;
        access_size_e            rsize;
    } bus_req_t;

    // Decoded target of the current request
    typedef struct packed {
        logic       is_simple; // Simple byte window
        logic [3:0] idx;       // Slot index within its window type
        logic [5:0] offset;    // Register offset within the window
    } peri_sel_t;

endpackage

/* hw/peri_map_pkg.sv */
/*
 * Address map types: peripheral identifiers, the per-pin function select
 * and the response every simple slot drives back to the hub.
 */

`include "peri_config.svh"

package peri_map_pkg;

    typedef logic [$clog2(`PERI_NUM_USER)-1:0] peri_id_t;

    // Full slot index of the GPIO block
    localparam peri_id_t PERI_ID_GPIO = 4'd1;

    typedef struct packed {
        logic     simple; // Source is a simple slot
        peri_id_t src;    // Slot or full peripheral index
    } pin_fsel_t;

    typedef struct packed {
        logic [7:0] rdata; // Read byte at the addressed offset
        logic [7:0] pins;  // Pin drive from this slot
    } slot_rsp_t;

endpackage

/* hw/peri_addr_decode.sv */
/*
 * Splits the core address into window type, slot index and offset,
 * and raises the write strobe of the slot being written.
 */

`timescale 1ns/1ps

`include "peri_config.svh"

module peri_addr_decode
    import peri_bus_pkg::*;
    import peri_map_pkg::*;
(
    input  bus_req_t                    i_bus,
    output peri_sel_t                   o_sel,
    output logic [`PERI_NUM_SIMPLE-1:0] o_slot_we,
    output logic                        o_gpio_we
);

    localparam int SLOT_IW = $clog2(`PERI_NUM_SIMPLE);

    logic wr_req;

    assign wr_req = (i_bus.wsize != SIZE_NONE);

    always_comb begin
        o_sel           = '0;
        o_slot_we       = '0;
        o_gpio_we       = 1'b0;
        o_sel.is_simple = i_bus.addr[10];

        if (i_bus.addr[10]) begin
            o_sel.idx    = i_bus.addr[7:4];          // 16-byte windows
            o_sel.offset = {2'b00, i_bus.addr[3:0]};
        end else begin
            o_sel.idx    = i_bus.addr[9:6];          // 64-byte windows
            o_sel.offset = i_bus.addr[5:0];
        end

        // Only existing targets get a strobe
        if (wr_req) begin
            if (o_sel.is_simple && int'(o_sel.idx) < `PERI_NUM_SIMPLE) begin
                o_slot_we[o_sel.idx[SLOT_IW-1:0]] = 1'b1;
            end else if (!o_sel.is_simple && o_sel.idx == PERI_ID_GPIO) begin
                o_gpio_we = 1'b1;
            end
        end
    end

endmodule

/* hw/byte_port_slot.sv */
/*
 * Generic simple byte peripheral: an output byte that drives the pins,
 * a scratch byte, input readback and a wrapping write counter.
 */

`timescale 1ns/1ps

module byte_port_slot
    import peri_map_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_we,
    input  logic [3:0] i_offset,
    input  logic [7:0] i_wdata,
    input  logic [7:0] i_ui_in,
    output slot_rsp_t  o_rsp
);

    localparam logic [3:0] OFS_OUT     = 4'h0;
    localparam logic [3:0] OFS_SCRATCH = 4'h1;
    localparam logic [3:0] OFS_IN      = 4'h2;
    localparam logic [3:0] OFS_COUNT   = 4'h3;

    logic [7:0] out_byte;
    logic [7:0] scratch;
    logic [7:0] wr_count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_byte <= 8'h00;
            wr_count <= 8'h00;
        end else if (i_we) begin
            wr_count <= wr_count + 8'd1; // Any offset counts
            if (i_offset == OFS_OUT) out_byte <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (i_we && i_offset == OFS_SCRATCH) scratch <= i_wdata;
    end

    always_comb begin
        case (i_offset)
            OFS_OUT:     o_rsp.rdata = out_byte;
            OFS_SCRATCH: o_rsp.rdata = scratch;
            OFS_IN:      o_rsp.rdata = i_ui_in;
            OFS_COUNT:   o_rsp.rdata = wr_count;
            default:     o_rsp.rdata = 8'h00;
        endcase
    end

    assign o_rsp.pins = out_byte;

endmodule

/* hw/gpio_ctrl.sv */
/*
 * GPIO block: output byte, input readback and one function select per pin.
 * The selects route each output pin to GPIO, to a simple slot, or to zero.
 */

`timescale 1ns/1ps

`include "peri_config.svh"

module gpio_ctrl
    import peri_bus_pkg::*;
    import peri_map_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_we,
    input  peri_sel_t              i_sel,
    input  logic [`PERI_DATA_W-1:0] i_wdata,
    input  logic [7:0]             i_ui_in,
    input  slot_rsp_t              i_slot_rsp [`PERI_NUM_SIMPLE],
    output logic [`PERI_DATA_W-1:0] o_rdata,
    output logic [7:0]             o_uo_out
);

    localparam int PIN_IW  = $clog2(`PERI_PINS);
    localparam int SLOT_IW = $clog2(`PERI_NUM_SIMPLE);

    logic [7:0]        gpio_out;
    pin_fsel_t         fsel [`PERI_PINS];
    logic              fsel_hit;
    logic [PIN_IW-1:0] fsel_pin;

    // Function selects sit on word boundaries from the FSEL base
    assign fsel_hit = (i_sel.offset >= `GPIO_OFS_FSEL) && (i_sel.offset[1:0] == 2'b00);
    assign fsel_pin = i_sel.offset[PIN_IW+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= 8'h00;
            for (int p = 0; p < `PERI_PINS; p++) begin
                fsel[p] <= '{simple: 1'b0, src: PERI_ID_GPIO}; // All pins on GPIO
            end
        end else if (i_we) begin
            if (i_sel.offset == `GPIO_OFS_OUT) begin
                gpio_out <= i_wdata[7:0];
            end else if (fsel_hit) begin
                fsel[fsel_pin] <= pin_fsel_t'(i_wdata[4:0]);
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_sel.offset == `GPIO_OFS_OUT) begin
            o_rdata[7:0] = gpio_out;
        end else if (i_sel.offset == `GPIO_OFS_IN) begin
            o_rdata[7:0] = i_ui_in;
        end else if (fsel_hit) begin
            o_rdata[4:0] = fsel[fsel_pin];
        end
    end

    // Output pin routing
    always_comb begin
        o_uo_out = 8'h00;
        for (int p = 0; p < `PERI_PINS; p++) begin
            if (fsel[p].simple) begin
                if (int'(fsel[p].src) < `PERI_NUM_SIMPLE) begin
                    o_uo_out[p] = i_slot_rsp[fsel[p].src[SLOT_IW-1:0]].pins[p];
                end
            end else if (fsel[p].src == PERI_ID_GPIO) begin
                o_uo_out[p] = gpio_out[p];
            end
            // Absent slots leave the pin low
        end
    end

endmodule

/* hw/read_return.sv */
/*
 * Read return path: selects the addressed source word, captures it on a
 * read and holds it until the core signals read complete.
 */

`timescale 1ns/1ps

`include "peri_config.svh"

module read_return
    import peri_bus_pkg::*;
    import peri_map_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  bus_req_t                i_bus,
    input  peri_sel_t               i_sel,
    input  slot_rsp_t               i_slot_rsp [`PERI_NUM_SIMPLE],
    input  logic [`PERI_DATA_W-1:0] i_gpio_rdata,
    input  logic                    i_data_read_complete,
    output logic [`PERI_DATA_W-1:0] o_data_out,
    output logic                    o_data_ready
);

    localparam int SLOT_IW = $clog2(`PERI_NUM_SIMPLE);

    logic                    rd_req;
    logic                    wr_req;
    logic                    rd_eff;
    logic                    ready_r;
    logic                    hold;
    logic [`PERI_DATA_W-1:0] src_word;
    logic [`PERI_DATA_W-1:0] data_r;

    assign rd_req = (i_bus.rsize != SIZE_NONE);
    assign wr_req = (i_bus.wsize != SIZE_NONE);
    assign rd_eff = rd_req && !ready_r; // No second capture while ready is up

    always_comb begin
        src_word = '0;
        if (i_sel.is_simple) begin
            if (int'(i_sel.idx) < `PERI_NUM_SIMPLE) begin
                src_word[7:0] = i_slot_rsp[i_sel.idx[SLOT_IW-1:0]].rdata;
            end
        end else if (i_sel.idx == PERI_ID_GPIO) begin
            src_word = i_gpio_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_data_read_complete) hold <= 1'b0;
            if (rd_eff && !hold) hold <= 1'b1; // Capture wins over complete
            ready_r <= rd_eff;                 // All sources answer in one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (rd_eff && !hold) data_r <= src_word;
    end

    assign o_data_out   = data_r;
    assign o_data_ready = ready_r || wr_req; // Writes complete in the same cycle

endmodule

/* hw/peri_bus_top.sv */
/*
 * Peripheral hub top level. Connects the address decoder, the row of
 * simple byte slots, the GPIO block and the read return path.
 */

`timescale 1ns/1ps

`include "peri_config.svh"

module peri_bus_top
    import peri_bus_pkg::*;
    import peri_map_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  bus_req_t                i_bus,
    input  logic [7:0]              i_ui_in,
    input  logic                    i_data_read_complete,
    output logic [`PERI_DATA_W-1:0] o_data_out,
    output logic                    o_data_ready,
    output logic [7:0]              o_uo_out
);

    peri_sel_t                   sel;
    logic [`PERI_NUM_SIMPLE-1:0] slot_we;
    logic                        gpio_we;
    slot_rsp_t                   slot_rsp [`PERI_NUM_SIMPLE];
    logic [`PERI_DATA_W-1:0]     gpio_rdata;

    peri_addr_decode i_peri_addr_decode (
        .i_bus     (i_bus),
        .o_sel     (sel),
        .o_slot_we (slot_we),
        .o_gpio_we (gpio_we)
    );

    // Simple slots only see the low data byte
    for (genvar s = 0; s < `PERI_NUM_SIMPLE; s++) begin : g_slot
        byte_port_slot i_byte_port_slot (
            .clk      (clk),
            .rst_n    (rst_n),
            .i_we     (slot_we[s]),
            .i_offset (sel.offset[3:0]),
            .i_wdata  (i_bus.wdata[7:0]),
            .i_ui_in  (i_ui_in),
            .o_rsp    (slot_rsp[s])
        );
    end

    gpio_ctrl i_gpio_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_we       (gpio_we),
        .i_sel      (sel),
        .i_wdata    (i_bus.wdata),
        .i_ui_in    (i_ui_in),
        .i_slot_rsp (slot_rsp),
        .o_rdata    (gpio_rdata),
        .o_uo_out   (o_uo_out)
    );

    read_return i_read_return (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_bus                (i_bus),
        .i_sel                (sel),
        .i_slot_rsp           (slot_rsp),
        .i_gpio_rdata         (gpio_rdata),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

endmodule

/* tb/peri_bus_props.sv */
/*
 * Handshake properties for the read return path, bound into read_return
 * from the testbench.
 */

`timescale 1ns/1ps

`include "peri_config.svh"

module peri_bus_props
    import peri_bus_pkg::*;
(
    input logic                    clk,
    input logic                    rst_n,
    input bus_req_t                i_bus,
    input logic [`PERI_DATA_W-1:0] o_data_out,
    input logic                    o_data_ready,
    input logic                    i_hold
);

    logic rd_req;
    logic wr_req;

    assign rd_req = (i_bus.rsize != SIZE_NONE);
    assign wr_req = (i_bus.wsize != SIZE_NONE);

    ready_after_reset: assert property (@(posedge clk) !rst_n |=> !o_data_ready)
        else $error("o_data_ready high in the cycle after reset");

    // Captured word may not move until read complete
    data_held: assert property (@(posedge clk) disable iff (!rst_n)
        i_hold |=> $stable(o_data_out))
        else $error("o_data_out changed while a capture was held");

    ready_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(o_data_ready) |-> (wr_req || $past(rd_req)))
        else $error("o_data_ready rose without a read or write request");

endmodule

/* tb/peri_bus_tb.sv */
/*
 * Testbench for the peripheral hub. Drives core bus reads and writes, keeps
 * a model of the address map and compares read data and output pins to it.
 */

`timescale 1ns/1ps

`include "peri_config.svh"

module peri_bus_tb
    import peri_bus_pkg::*;
    import peri_map_pkg::*;
();

    localparam int MAX_WAIT = 20; // Cycles before a wait gives up

    logic                    clk;
    logic                    rst_n;
    bus_req_t                bus;
    logic [7:0]              ui_in;
    logic                    read_complete;
    logic [`PERI_DATA_W-1:0] data_out;
    logic                    data_ready;
    logic [7:0]              uo_out;

    int   errors;
    int   checks;
    int   tests;
    int   test_err;
    logic pin_check_en;

    // Model of the address map
    logic [7:0] gpio_out_m;
    pin_fsel_t  fsel_m [`PERI_PINS];
    logic [7:0] slot_out_m [`PERI_NUM_SIMPLE];
    logic [7:0] slot_scr_m [`PERI_NUM_SIMPLE];
    logic [7:0] slot_cnt_m [`PERI_NUM_SIMPLE];

    peri_bus_top i_peri_bus_top (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_bus                (bus),
        .i_ui_in              (ui_in),
        .i_data_read_complete (read_complete),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .o_uo_out             (uo_out)
    );

    bind read_return peri_bus_props i_peri_bus_props (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_bus        (i_bus),
        .o_data_out   (o_data_out),
        .o_data_ready (o_data_ready),
        .i_hold       (hold)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [10:0] simple_addr(input int idx, input int ofs);
        return {1'b1, 2'b00, idx[3:0], ofs[3:0]};
    endfunction

    function automatic logic [10:0] full_addr(input int idx, input int ofs);
        return {1'b0, idx[3:0], ofs[5:0]};
    endfunction

    // Expected read word for an address from the model state
    function automatic logic [31:0] expected_read(input logic [10:0] addr);
        logic [3:0]  idx;
        logic [5:0]  ofs;
        logic [31:0] r;
        r = '0;
        if (addr[10]) begin
            idx = addr[7:4];
            ofs = {2'b00, addr[3:0]};
            if (int'(idx) < `PERI_NUM_SIMPLE) begin
                case (ofs)
                    6'h0:    r[7:0] = slot_out_m[idx[2:0]];
                    6'h1:    r[7:0] = slot_scr_m[idx[2:0]];
                    6'h2:    r[7:0] = ui_in;
                    6'h3:    r[7:0] = slot_cnt_m[idx[2:0]];
                    default: r = '0;
                endcase
            end
        end else begin
            idx = addr[9:6];
            ofs = addr[5:0];
            if (idx == PERI_ID_GPIO) begin
                if (ofs == `GPIO_OFS_OUT) r[7:0] = gpio_out_m;
                else if (ofs == `GPIO_OFS_IN) r[7:0] = ui_in;
                else if (ofs >= `GPIO_OFS_FSEL && ofs[1:0] == 2'b00) r[4:0] = fsel_m[ofs[4:2]];
            end
        end
        return r;
    endfunction

    function automatic logic [7:0] expected_pins();
        logic [7:0] r;
        r = 8'h00;
        for (int p = 0; p < `PERI_PINS; p++) begin
            if (fsel_m[p].simple) begin
                if (int'(fsel_m[p].src) < `PERI_NUM_SIMPLE) begin
                    r[p] = slot_out_m[fsel_m[p].src[2:0]][p];
                end
            end else if (fsel_m[p].src == PERI_ID_GPIO) begin
                r[p] = gpio_out_m[p];
            end
        end
        return r;
    endfunction

    function automatic void model_write(input logic [10:0] addr, input logic [31:0] data);
        logic [3:0] idx;
        logic [5:0] ofs;
        if (addr[10]) begin
            idx = addr[7:4];
            ofs = {2'b00, addr[3:0]};
            if (int'(idx) < `PERI_NUM_SIMPLE) begin
                slot_cnt_m[idx[2:0]] = slot_cnt_m[idx[2:0]] + 8'd1; // Wraps at 256
                if (ofs == 6'h0) slot_out_m[idx[2:0]] = data[7:0];
                if (ofs == 6'h1) slot_scr_m[idx[2:0]] = data[7:0];
            end
        end else begin
            idx = addr[9:6];
            ofs = addr[5:0];
            if (idx == PERI_ID_GPIO) begin
                if (ofs == `GPIO_OFS_OUT) gpio_out_m = data[7:0];
                else if (ofs >= `GPIO_OFS_FSEL && ofs[1:0] == 2'b00)
                    fsel_m[ofs[4:2]] = pin_fsel_t'(data[4:0]);
            end
        end
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == test_err) ? "ok" : "mismatch");
        test_err = errors;
    endtask

    // Tasks start and end 2 ns after a rising edge
    task automatic bus_write(input logic [10:0] addr, input logic [31:0] data);
        int waited;
        waited    = 0;
        bus.addr  = addr;
        bus.wdata = data;
        bus.wsize = SIZE_BYTE;
        #1;
        while (!data_ready && waited < MAX_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!data_ready) begin
            errors++;
            $display("timeout: no ready for the write to address %h", addr);
        end
        @(posedge clk);
        model_write(addr, data);
        #2;
        bus.wsize = SIZE_NONE;
    endtask

    task automatic read_request(input logic [10:0] addr, output logic [31:0] data,
                                output int cycles);
        cycles    = 0;
        bus.addr  = addr;
        bus.rsize = SIZE_WORD;
        #1;
        // Ready already up in the request cycle counts as zero cycles
        while (!data_ready && cycles < MAX_WAIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!data_ready) begin
            errors++;
            $display("timeout: no ready for the read from address %h", addr);
        end
        data = data_out;
        #1;
        bus.rsize = SIZE_NONE;
    endtask

    task automatic read_release();
        read_complete = 1'b1;
        @(posedge clk);
        #2;
        read_complete = 1'b0;
    endtask

    task automatic check_read(input logic [10:0] addr);
        logic [31:0] exp;
        logic [31:0] got;
        int          cycles;
        exp = expected_read(addr);
        read_request(addr, got, cycles);
        read_release();
        check("o_data_out", exp, got);
    endtask

    // Pins are compared against the model on every falling edge
    always @(negedge clk) begin
        if (pin_check_en) check("o_uo_out", {24'h0, expected_pins()}, {24'h0, uo_out});
    end

    initial begin
        logic [31:0] d;
        logic [10:0] a;
        int          cyc;
        int          pin;

        void'($urandom(77785));
        bus           = '{addr: '0, wdata: '0, wsize: SIZE_NONE, rsize: SIZE_NONE};
        ui_in         = 8'h00;
        read_complete = 1'b0;
        rst_n         = 1'b0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        test_err      = 0;
        pin_check_en  = 1'b0;
        gpio_out_m    = 8'h00;
        for (int p = 0; p < `PERI_PINS; p++) fsel_m[p] = '{simple: 1'b0, src: PERI_ID_GPIO};
        for (int s = 0; s < `PERI_NUM_SIMPLE; s++) begin
            slot_out_m[s] = 8'h00;
            slot_scr_m[s] = 8'h00;
            slot_cnt_m[s] = 8'h00;
        end

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk); // Idle cycle after reset
        #2;
        pin_check_en = 1'b1;

        for (int p = 0; p < `PERI_PINS; p++) begin
            check_read(full_addr(PERI_ID_GPIO, `GPIO_OFS_FSEL + 4 * p));
        end
        check_read(full_addr(PERI_ID_GPIO, `GPIO_OFS_OUT));
        check("o_uo_out", 32'h0, {24'h0, uo_out});
        end_test("reset_state");

        repeat (4) begin
            d = $urandom;
            bus_write(full_addr(PERI_ID_GPIO, `GPIO_OFS_OUT), d);
            check_read(full_addr(PERI_ID_GPIO, `GPIO_OFS_OUT));
            check("o_uo_out", {24'h0, d[7:0]}, {24'h0, uo_out});
        end
        ui_in = 8'($urandom);
        check_read(full_addr(PERI_ID_GPIO, `GPIO_OFS_IN));
        end_test("gpio");

        for (int s = 0; s < `PERI_NUM_SIMPLE; s++) begin
            ui_in = 8'($urandom);
            bus_write(simple_addr(s, 0), $urandom);
            bus_write(simple_addr(s, 1), $urandom);
            bus_write(simple_addr(s, 2), $urandom); // Read-only offset still counts
            for (int o = 0; o < 4; o++) check_read(simple_addr(s, o));
        end
        repeat (254) bus_write(simple_addr(5, 1), $urandom); // Counter wraps
        check_read(simple_addr(5, 3));
        end_test("slots");

        bus_write(full_addr(PERI_ID_GPIO, `GPIO_OFS_OUT), $urandom);
        repeat (16) begin
            pin = $urandom_range(7, 0);
            if ($urandom_range(1, 0) == 1) d = {27'h0, 1'b1, 4'($urandom)};
            else d = {28'h0, 4'($urandom)};
            a = full_addr(PERI_ID_GPIO, `GPIO_OFS_FSEL + 4 * pin);
            bus_write(a, d);
            check_read(a);
            bus_write(simple_addr($urandom_range(7, 0), 0), $urandom);
            check("o_uo_out", {24'h0, expected_pins()}, {24'h0, uo_out});
        end
        end_test("pin_routing");

        for (int i = `PERI_NUM_SIMPLE; i < 16; i++) begin
            bus_write(simple_addr(i, 0), $urandom);
            check_read(simple_addr(i, $urandom_range(3, 0)));
        end
        for (int i = 0; i < `PERI_NUM_USER; i++) begin
            if (i != PERI_ID_GPIO) begin
                bus_write(full_addr(i, 0), $urandom);
                check_read(full_addr(i, 4 * $urandom_range(15, 0)));
            end
        end
        for (int s = 0; s < `PERI_NUM_SIMPLE; s++) begin
            for (int o = 0; o < 4; o++) check_read(simple_addr(s, o));
        end
        check_read(full_addr(PERI_ID_GPIO, `GPIO_OFS_OUT));
        end_test("unmapped");

        a = simple_addr(2, 0);
        bus_write(a, 32'h5a);
        read_request(a, d, cyc);
        check("o_data_ready", 32'd1, cyc);
        check("o_data_out", 32'h5a, d);
        bus_write(a, 32'ha5); // Target changes while the capture is held
        bus.rsize = SIZE_WORD; // Repeated read before read complete
        repeat (4) begin
            @(posedge clk);
            #1;
            check("o_data_out", 32'h5a, data_out);
            #1;
        end
        bus.rsize = SIZE_NONE;
        read_release();
        read_request(a, d, cyc);
        check("o_data_ready", 32'd1, cyc);
        check("o_data_out", 32'ha5, d);
        read_release();
        end_test("read_handshake");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
hw/peri_bus_pkg.sv
hw/peri_map_pkg.sv
hw/peri_addr_decode.sv
hw/byte_port_slot.sv
hw/gpio_ctrl.sv
hw/read_return.sv
hw/peri_bus_top.sv
tb/peri_bus_props.sv
tb/peri_bus_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the peripheral hub testbench with Verilator and runs it
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module peri_bus_tb \
    -o peri_bus_sim

./obj_dir/peri_bus_sim | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation finished without failures"
